// ==== common/ifu_defs.svh ====
// Sizing macros for the instruction fetch unit.
// Included by the package and by any block that needs a raw size.

`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// ------------------------------------------------
// Instruction queue
// ------------------------------------------------

// Depth in 16-bit parcels, two memory words
`define IFU_Q_SIZE_HALF 4

// ------------------------------------------------
// Memory side
// ------------------------------------------------

// Pending transaction counter, saturates at 7
`define IFU_TXN_CNT_W 3

// Address and instruction width
`define IFU_XLEN 32

`endif

// ==== common/ifu_pkg.sv ====
// Types shared by the fetch unit blocks and its testbench.
// Import where needed; sizes come from the defs header.

`include "ifu_defs.svh"

package ifu_pkg;

    typedef logic [`IFU_XLEN-1:0]                addr_t;      // Byte address
    typedef logic [`IFU_XLEN-1:2]                word_addr_t; // Word address
    typedef logic [15:0]                         half_t;      // One parcel
    typedef logic [`IFU_XLEN-1:0]                instr_t;
    typedef logic [`IFU_TXN_CNT_W-1:0]           txn_cnt_t;
    typedef logic [$clog2(`IFU_Q_SIZE_HALF):0]   q_ptr_t;     // Extra bit for wrap

    typedef enum logic {FSM_IDLE = 1'b0, FSM_FETCH = 1'b1} fetch_state_e;

    typedef enum logic [1:0] {RESP_NONE = 2'd0, RESP_OK = 2'd1, RESP_ERR = 2'd2} imem_resp_e;

    // Queue write command
    typedef enum logic [1:0] {WR_NONE = 2'd0, WR_FULL = 2'd1, WR_HI = 2'd2} q_wr_e;

    // Contents of a response word, named upper part first
    typedef enum logic [2:0] {
        RD_NONE          = 3'd0,
        RD_RVI_HI_RVI_LO = 3'd1,   // Whole 32-bit instruction
        RD_RVC_RVC       = 3'd2,
        RD_RVI_LO_RVC    = 3'd3,
        RD_RVC_RVI_HI    = 3'd4,
        RD_RVI_LO_RVI_HI = 3'd5,
        RD_RVC_NV        = 3'd6,   // Lower parcel skipped, unaligned target
        RD_RVI_LO_NV     = 3'd7
    } rdata_kind_e;

    typedef struct packed {logic req; addr_t addr;} imem_req_s;

    typedef struct packed {imem_resp_e resp; instr_t rdata;} imem_rsp_s;

    typedef struct packed {logic new_pc_req; addr_t new_pc; logic stop_fetch;} redirect_s;

    typedef struct packed {logic vld; instr_t instr; logic err;} fetch_out_s;

endpackage

// ==== hw/fetch/fetch_ctrl.sv ====
// Memory-side control of the fetch unit.
// Runs the IDLE/FETCH machine, the word address register and the
// pending/discard counters, and throttles requests against queue space.

`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ifu_pkg::redirect_s   redir,
    input  logic                 imem_ack,
    input  ifu_pkg::imem_rsp_s   imem_in,
    input  logic [1:0]           q_free_words,
    output ifu_pkg::imem_req_s   imem_out,
    output logic                 txns_pending,
    output logic                 discard,
    output logic                 resp_vd,
    output logic                 resp_err_vd
);
    import ifu_pkg::*;

    fetch_state_e  state, state_nxt;
    word_addr_t    addr_r;
    word_addr_t    addr_base;
    txn_cnt_t      pend_cnt, pend_cnt_nxt;
    txn_cnt_t      disc_cnt, disc_cnt_nxt;
    txn_cnt_t      vd_pending;
    logic          resp_any;
    logic          cnt_full;
    logic          accepted;

    // ------------------------------------------------
    // Response decode
    // ------------------------------------------------
    assign resp_any    = (imem_in.resp == RESP_OK) | (imem_in.resp == RESP_ERR);
    assign discard     = |disc_cnt;
    assign resp_vd     = resp_any & ~discard;
    assign resp_err_vd = (imem_in.resp == RESP_ERR) & ~discard;

    // A returning response frees a slot in the same cycle
    assign cnt_full    = (&pend_cnt) & ~resp_any;
    assign vd_pending  = pend_cnt - disc_cnt;

    // ------------------------------------------------
    // Request
    // ------------------------------------------------
    assign addr_base     = redir.new_pc_req ? redir.new_pc[31:2] : addr_r;
    assign imem_out.addr = {addr_base, 2'b00};
    assign imem_out.req  = ~redir.stop_fetch & ~cnt_full &
                           (redir.new_pc_req |
                            ((state == FSM_FETCH) &
                             (txn_cnt_t'(q_free_words) > vd_pending)));
    assign accepted      = imem_out.req & imem_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_r <= '0;
        end else if (accepted) begin
            addr_r <= addr_base + word_addr_t'(1);
        end else if (redir.new_pc_req) begin
            addr_r <= redir.new_pc[31:2];   // Target waits for an ack
        end
    end

    // ------------------------------------------------
    // Pending and discard counters
    // ------------------------------------------------
    assign pend_cnt_nxt = pend_cnt + txn_cnt_t'(accepted) - txn_cnt_t'(resp_any);
    assign txns_pending = |pend_cnt;

    always_comb begin
        if (redir.new_pc_req | redir.stop_fetch) begin
            disc_cnt_nxt = pend_cnt - txn_cnt_t'(resp_any);   // Everything older is stale
        end else if (resp_err_vd) begin
            disc_cnt_nxt = pend_cnt_nxt;                      // Drop the rest after a fault
        end else begin
            disc_cnt_nxt = disc_cnt - txn_cnt_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_cnt <= '0;
            disc_cnt <= '0;
        end else begin
            pend_cnt <= pend_cnt_nxt;
            if (redir.new_pc_req | redir.stop_fetch | resp_err_vd | (resp_any & discard)) begin
                disc_cnt <= disc_cnt_nxt;
            end
        end
    end

    // ------------------------------------------------
    // State machine
    // ------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            FSM_IDLE:  if (redir.new_pc_req & ~redir.stop_fetch) state_nxt = FSM_FETCH;
            FSM_FETCH: if (redir.stop_fetch | (resp_err_vd & ~redir.new_pc_req)) begin
                state_nxt = FSM_IDLE;
            end
            default:   state_nxt = FSM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FSM_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

// ==== hw/fetch/resp_align.sv ====
// Response identification for the fetch unit.
// Looks at each accepted response word and decides how much of it
// goes into the instruction queue.

`timescale 1ns/1ns

module resp_align (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ifu_pkg::redirect_s   redir,
    input  ifu_pkg::imem_rsp_s   imem_in,
    input  logic                 discard,
    input  logic                 resp_vd,
    output ifu_pkg::q_wr_e       q_wr
);
    import ifu_pkg::*;

    rdata_kind_e  kind;
    logic         rvi_part2;     // Upper half of a 32-bit instr expected next
    logic         pc_unaligned;  // First word after a target with bit 1 set
    logic         lo_rvi;
    logic         hi_rvi;

    assign lo_rvi = &imem_in.rdata[1:0];
    assign hi_rvi = &imem_in.rdata[17:16];

    always_comb begin
        kind = RD_NONE;
        if ((imem_in.resp == RESP_OK) & ~discard) begin
            if (pc_unaligned) begin
                kind = hi_rvi ? RD_RVI_LO_NV : RD_RVC_NV;
            end else if (rvi_part2) begin
                kind = hi_rvi ? RD_RVI_LO_RVI_HI : RD_RVC_RVI_HI;
            end else if (lo_rvi) begin
                kind = RD_RVI_HI_RVI_LO;
            end else begin
                kind = hi_rvi ? RD_RVI_LO_RVC : RD_RVC_RVC;
            end
        end
    end

    // Error words go in whole so decode sees the fault
    always_comb begin
        q_wr = WR_NONE;
        if (resp_vd) begin
            if ((kind == RD_RVC_NV) | (kind == RD_RVI_LO_NV)) q_wr = WR_HI;
            else                                              q_wr = WR_FULL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvi_part2    <= 1'b0;
            pc_unaligned <= 1'b0;
        end else if (redir.new_pc_req) begin
            rvi_part2    <= 1'b0;
            pc_unaligned <= redir.new_pc[1];
        end else if (resp_vd) begin
            rvi_part2    <= (kind == RD_RVI_LO_NV) | (kind == RD_RVI_LO_RVI_HI) |
                            (kind == RD_RVI_LO_RVC);
            pc_unaligned <= 1'b0;
        end
    end

endmodule

// ==== hw/fetch/instr_queue.sv ====
// Halfword instruction queue between memory responses and decode.
// Rebuilds 16- and 32-bit instructions from parcels and presents one
// per cycle with vld/rdy. Flushed by a redirect or a stop.

`timescale 1ns/1ns
`include "ifu_defs.svh"

module instr_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ifu_pkg::redirect_s   redir,
    input  ifu_pkg::q_wr_e       q_wr,
    input  ifu_pkg::instr_t      rdata,
    input  logic                 resp_err_vd,
    input  logic                 rdy,
    output logic [1:0]           q_free_words,
    output ifu_pkg::fetch_out_s  fetch
);
    import ifu_pkg::*;

    localparam int ADR_W = $clog2(`IFU_Q_SIZE_HALF);

    half_t             q_data [`IFU_Q_SIZE_HALF];
    logic              q_err  [`IFU_Q_SIZE_HALF];
    q_ptr_t            rptr, rptr_nxt;
    q_ptr_t            wptr, wptr_nxt;
    q_ptr_t            occupied;
    q_ptr_t            free_h;
    logic [ADR_W-1:0]  wadr, wadr1;
    logic [ADR_W-1:0]  radr, radr1;
    half_t             head, next;
    logic              head_err, next_err;
    logic              head_rvc;
    logic              two_held;
    logic              flush;
    logic              rd;

    assign flush = redir.new_pc_req | redir.stop_fetch;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    assign wadr  = wptr[ADR_W-1:0];
    assign wadr1 = wadr + 1'b1;

    always_ff @(posedge clk) begin
        if (q_wr == WR_HI) begin
            q_data[wadr] <= rdata[31:16];
            q_err[wadr]  <= resp_err_vd;
        end else if (q_wr == WR_FULL) begin
            q_data[wadr]  <= rdata[15:0];
            q_err[wadr]   <= resp_err_vd;
            q_data[wadr1] <= rdata[31:16];
            q_err[wadr1]  <= resp_err_vd;
        end
    end

    // ------------------------------------------------
    // Decode side
    // ------------------------------------------------
    assign radr     = rptr[ADR_W-1:0];
    assign radr1    = radr + 1'b1;
    assign head     = q_data[radr];
    assign next     = q_data[radr1];
    assign head_err = q_err[radr];
    assign next_err = q_err[radr1];

    assign occupied = wptr - rptr;
    assign two_held = occupied >= q_ptr_t'(2);
    assign head_rvc = head[1:0] != 2'b11;

    always_comb begin
        fetch.vld   = (occupied != '0) & (head_rvc | head_err | two_held);
        fetch.instr = head_rvc ? {16'h0, head} : {next, head};
        fetch.err   = (occupied != '0) & (head_err | (~head_rvc & two_held & next_err));
    end

    assign rd = fetch.vld & rdy;

    // ------------------------------------------------
    // Pointers
    // ------------------------------------------------
    always_comb begin
        rptr_nxt = rptr;
        if (rd) begin
            if (fetch.err)     rptr_nxt = wptr;   // Fetch halts, nothing after is valid
            else if (head_rvc) rptr_nxt = rptr + q_ptr_t'(1);
            else               rptr_nxt = rptr + q_ptr_t'(2);
        end
    end

    always_comb begin
        case (q_wr)
            WR_FULL: wptr_nxt = wptr + q_ptr_t'(2);
            WR_HI:   wptr_nxt = wptr + q_ptr_t'(1);
            default: wptr_nxt = wptr;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;
            wptr <= '0;
        end else begin
            rptr <= rptr_nxt;
            wptr <= wptr_nxt;
        end
    end

    // Free space after this cycle's read, in whole words
    assign free_h       = q_ptr_t'(`IFU_Q_SIZE_HALF) - (wptr - rptr_nxt);
    assign q_free_words = free_h[ADR_W:1];

endmodule

// ==== hw/ifu_top.sv ====
// Instruction fetch unit top level.
// Memory request/response port on one side, decode valid/ready on the other.
// Fetch starts on a redirect from the pipeline and halts on stop or error.

`timescale 1ns/1ns

module ifu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ifu_pkg::redirect_s     redir,
    output ifu_pkg::imem_req_s     imem_out,
    input  logic                   imem_ack,
    input  ifu_pkg::imem_rsp_s     imem_in,
    output logic                   txns_pending,
    output ifu_pkg::fetch_out_s    fetch,
    input  logic                   rdy
);
    import ifu_pkg::*;

    logic        discard;       // Stale responses still on the way
    logic        resp_vd;
    logic        resp_err_vd;
    q_wr_e       q_wr;
    logic [1:0]  q_free_words;

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .redir        (redir),
        .imem_ack     (imem_ack),
        .imem_in      (imem_in),
        .q_free_words (q_free_words),
        .imem_out     (imem_out),
        .txns_pending (txns_pending),
        .discard      (discard),
        .resp_vd      (resp_vd),
        .resp_err_vd  (resp_err_vd)
    );

    resp_align u_resp_align (
        .clk     (clk),
        .rst_n   (rst_n),
        .redir   (redir),
        .imem_in (imem_in),
        .discard (discard),
        .resp_vd (resp_vd),
        .q_wr    (q_wr)
    );

    instr_queue u_instr_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .redir        (redir),
        .q_wr         (q_wr),
        .rdata        (imem_in.rdata),
        .resp_err_vd  (resp_err_vd),
        .rdy          (rdy),
        .q_free_words (q_free_words),
        .fetch        (fetch)
    );

endmodule

// ==== verification/ifu_properties.sv ====
// Port-level assertions for the fetch unit, bound into ifu_top.
// Covers the reset state, stop behavior and the decode-side hold.

`timescale 1ns/1ns

module ifu_properties (
    input logic                 clk,
    input logic                 rst_n,
    input ifu_pkg::redirect_s   redir,
    input ifu_pkg::imem_req_s   imem_out,
    input ifu_pkg::fetch_out_s  fetch,
    input logic                 rdy
);
    import ifu_pkg::*;

    int unsigned fail_cnt = 0;   // Read by the testbench at the end

    // Memory port and decode side idle as reset releases
    a_reset_idle: assert property (
        @(posedge clk) $rose(rst_n) |-> !imem_out.req && !fetch.vld
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("req or vld high as reset releases");
    end

    a_stop_no_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        redir.stop_fetch |=> !imem_out.req || redir.new_pc_req
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("request issued after stop without a redirect");
    end

    // Decode sees the same instruction until it takes it
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch.vld && !rdy && !redir.new_pc_req && !redir.stop_fetch |=> $stable(fetch)
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("fetch output changed while decode stalled");
    end

    a_stop_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        redir.stop_fetch |=> !fetch.vld
    ) else begin
        fail_cnt = fail_cnt + 1;
        $error("vld high in the cycle after stop");
    end

endmodule

bind ifu_top ifu_properties u_ifu_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .redir    (redir),
    .imem_out (imem_out),
    .fetch    (fetch),
    .rdy      (rdy)
);

// ==== verification/ifu_tb.sv ====
// Testbench for the instruction fetch unit.
// A memory model answers every request with random latency; a table of
// redirect scenarios is applied and each instruction taken by decode is
// compared with a walk through the same memory image.

`timescale 1ns/1ns

module ifu_tb;
    import ifu_pkg::*;

    localparam int N_ROWS     = 6;
    // 150 instructions, a few cycles each with stalls and latency, plus margin
    localparam int MAX_CYCLES = 4000;

    localparam logic [1:0] ACT_NONE  = 2'd0;
    localparam logic [1:0] ACT_REDIR = 2'd1;
    localparam logic [1:0] ACT_STOP  = 2'd2;

    typedef struct packed {
        logic [7:0] pc;
        logic [7:0] count;
        logic       rand_rdy;
        logic [7:0] err_word;   // FF for no fault
        logic [1:0] action;     // Taken past halfway with a request in flight
    } row_s;

    row_s rows [N_ROWS] = '{
        //  pc     count  rand  err    action
        '{8'h00, 8'd20, 1'b0, 8'hFF, ACT_NONE},    // Aligned start
        '{8'h46, 8'd16, 1'b0, 8'hFF, ACT_NONE},    // Upper parcel first
        '{8'h80, 8'd30, 1'b1, 8'hFF, ACT_NONE},    // Decode stalls
        '{8'h10, 8'd40, 1'b0, 8'd12, ACT_NONE},    // Fault at 0x30
        '{8'hC2, 8'd24, 1'b1, 8'hFF, ACT_REDIR},
        '{8'hA4, 8'd20, 1'b1, 8'hFF, ACT_STOP}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    redirect_s   redir;
    imem_req_s   imem_out;
    logic        imem_ack;
    imem_rsp_s   imem_in;
    logic        txns_pending;
    fetch_out_s  fetch;
    logic        rdy;

    logic [31:0] mem [64];
    logic [31:0] lcg_state;
    int          err_word;
    int          cyc = 0;
    logic [31:0] mq_addr [$];   // Requests waiting for their response
    int          mq_due  [$];
    logic        mq_err  [$];

    ifu_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .redir        (redir),
        .imem_out     (imem_out),
        .imem_ack     (imem_ack),
        .imem_in      (imem_in),
        .txns_pending (txns_pending),
        .fetch        (fetch),
        .rdy          (rdy)
    );

    initial forever #2 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = lcg_next();
        return v[16];
    endfunction

    function automatic int rand_delay();
        logic [31:0] v;
        v = lcg_next();
        return 1 + int'(v[31:16]) % 3;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return mem[a[7:2]];
    endfunction

    function automatic logic [15:0] half_at(input logic [31:0] a);
        logic [31:0] w;
        w = mem_word(a);
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    function automatic logic word_err(input logic [31:0] a);
        return (err_word >= 0) && (int'(a[7:2]) == err_word);
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ------------------------------------------------
    // Memory model
    // ------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && imem_out.req && imem_ack) begin
            mq_addr.push_back(imem_out.addr);
            mq_due.push_back(cyc + rand_delay());
            mq_err.push_back(word_err(imem_out.addr));
            check_eq("memory transactions within capacity", mq_addr.size() <= 7, 1);
        end
    end

    always @(posedge clk) begin
        #1;
        imem_in.resp  = RESP_NONE;
        imem_in.rdata = '0;
        if (mq_addr.size() > 0 && mq_due[0] <= cyc) begin   // In order, one per cycle
            imem_in.resp  = mq_err[0] ? RESP_ERR : RESP_OK;
            imem_in.rdata = mem_word(mq_addr[0]);
            void'(mq_addr.pop_front());
            void'(mq_due.pop_front());
            void'(mq_err.pop_front());
        end
    end

    // ------------------------------------------------
    // Reference walker and stimulus
    // ------------------------------------------------
    // Low bits 11 mark a 32-bit instruction of two parcels
    task automatic predict(input logic [31:0] pc, output logic [31:0] instr,
                           output logic err, output int len);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = half_at(pc);
        hi = half_at(pc + 32'd2);
        if (lo[1:0] == 2'b11) begin
            instr = {hi, lo};
            err   = word_err(pc) | word_err(pc + 32'd2);
            len   = 4;
        end else begin
            instr = {16'h0, lo};
            err   = word_err(pc);
            len   = 2;
        end
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        redir.new_pc_req = 1'b1;
        redir.new_pc     = pc;
        rdy              = 1'b0;    // No transfer alongside the flush
        @(posedge clk);
        #1;
        redir.new_pc_req = 1'b0;
    endtask

    task automatic check_halted(input string why);
        check_eq({"vld ", why}, fetch.vld, 0);
        check_eq({"req ", why}, imem_out.req, 0);
    endtask

    task automatic stop_and_drain();
        redir.stop_fetch = 1'b1;
        rdy              = 1'b0;
        @(posedge clk);
        #1;
        redir.stop_fetch = 1'b0;
        rdy              = 1'b1;
        do begin
            @(negedge clk);
            check_halted("after stop");
        end while (txns_pending);
        check_eq("memory transactions left after stop", mq_addr.size(), 0);
        @(posedge clk);
        #1;
    endtask

    task automatic run_row(input row_s row);
        logic [31:0] wpc;
        logic [31:0] exp_instr;
        logic        exp_err;
        int          len;
        int          done;
        logic        faulted;
        logic        mid_done;
        err_word = (row.err_word == 8'hFF) ? -1 : int'(row.err_word);
        wpc      = {24'h0, row.pc};
        done     = 0;
        faulted  = 1'b0;
        mid_done = 1'b0;
        redirect_to(wpc);
        while (done < int'(row.count) && !faulted) begin
            if (!mid_done && row.action != ACT_NONE && done >= int'(row.count) / 2 &&
                txns_pending) begin
                mid_done = 1'b1;
                if (row.action == ACT_STOP) begin
                    stop_and_drain();
                    break;
                end
                wpc = {24'h0, (row.pc + 8'h5A) & 8'hFE};
                redirect_to(wpc);   // Responses in flight become stale
            end
            rdy = row.rand_rdy ? rand_bit() : 1'b1;
            @(negedge clk);
            if (fetch.vld && rdy) begin
                predict(wpc, exp_instr, exp_err, len);
                check_eq($sformatf("err flag at pc %h", wpc), fetch.err, exp_err);
                if (!exp_err) begin
                    check_eq($sformatf("instruction at pc %h", wpc), fetch.instr, exp_instr);
                end
                wpc     = wpc + len;
                done    = done + 1;
                faulted = exp_err;
            end
            @(posedge clk);
            #1;
        end
        if (row.action != ACT_NONE) begin
            check_eq("mid-run action taken while requests were in flight", mid_done, 1);
        end
        if (row.err_word != 8'hFF) begin
            check_eq("fault reached in row", faulted, 1);
            repeat (10) begin
                @(negedge clk);
                check_halted("after fault");
            end
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        logic [31:0] hi;
        logic [31:0] lo;
        rst_n     = 1'b0;
        redir     = '0;
        imem_ack  = 1'b1;   // Memory takes every request
        imem_in   = '0;
        rdy       = 1'b0;
        lcg_state = 32'd59517;
        err_word  = -1;
        for (int i = 0; i < 64; i++) begin
            hi     = lcg_next();
            lo     = lcg_next();
            mem[i] = {hi[31:16], lo[31:16]};
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(rows[r]);
        end
        if (DUT.u_ifu_properties.fail_cnt != 0) begin
            $display("Bound assertions failed %0d times", DUT.u_ifu_properties.fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+common
common/ifu_pkg.sv
hw/fetch/fetch_ctrl.sv
hw/fetch/resp_align.sv
hw/fetch/instr_queue.sv
hw/ifu_top.sv
verification/ifu_properties.sv
verification/ifu_tb.sv

// ==== Makefile ====
TOP = ifu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
